// File: halli_pkg.sv
`default_nettype none

package halli_pkg;

    // card fields
    localparam int COLOR_W = 2;
    localparam int NUM_W   = 3;

    // keypad
    localparam int KEY_W = 4;
    localparam logic [KEY_W-1:0] KEY_P1 = 4'd7;  // player a key
    localparam logic [KEY_W-1:0] KEY_P2 = 4'd9;  // player b key

    localparam int BONUS_W = 8;  // reaction bonus, unsigned

    typedef enum logic [1:0] {
        none     = 2'b00,
        player_a = 2'b01,
        player_b = 2'b10
    } player_t;

    // config register map
    localparam int CFG_ADDR_W = 1;
    localparam logic [CFG_ADDR_W-1:0] CFG_TARGET = 1'b0;
    localparam logic [CFG_ADDR_W-1:0] CFG_MARGIN = 1'b1;

    localparam logic [3:0] TARGET_DEFAULT = 4'd5;
    localparam logic [7:0] MARGIN_DEFAULT = 8'd50;

endpackage

`default_nettype wire

// File: card_if.sv
`default_nettype none

interface card_if;
    import halli_pkg::*;

    logic [COLOR_W-1:0] color1;
    logic [COLOR_W-1:0] color2;
    logic [NUM_W-1:0]   num1;
    logic [NUM_W-1:0]   num2;

    // dealer side
    modport driver (output color1, color2, num1, num2);

    modport judge (input color1, color2, num1, num2);

endinterface

`default_nettype wire

// File: game_config.sv
`default_nettype none

module game_config (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_we,
    input  logic [halli_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [7:0]                      cfg_wdata,
    output logic [3:0]                      target_sum,
    output logic [7:0]                      win_margin
);
    import halli_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst) begin
            target_sum <= TARGET_DEFAULT;
            win_margin <= MARGIN_DEFAULT;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_TARGET: target_sum <= cfg_wdata[3:0];  // upper nibble dropped
                CFG_MARGIN: win_margin <= cfg_wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: buzz_arbiter.sv
`default_nettype none

module buzz_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [halli_pkg::KEY_W-1:0] key,
    input  logic                       round_clear,
    output logic                       claim_valid,
    output halli_pkg::player_t         claim_player
);
    import halli_pkg::*;

    typedef enum logic [1:0] {
        idle   = 2'b00,
        held_a = 2'b01,
        held_b = 2'b10
    } lock_t;

    lock_t   state;
    player_t pending;  // press sampled last edge, not yet locked

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= idle;
            pending     <= none;
            claim_valid <= 1'b0;
        end else begin
            claim_valid <= 1'b0;
            pending     <= none;

            // keys only count while nobody holds the bell
            if (!round_clear && state == idle) begin
                if (key == KEY_P1)
                    pending <= player_a;
                else if (key == KEY_P2)
                    pending <= player_b;
            end

            if (round_clear) begin
                state <= idle;  // drops a pending press too
            end else if (state == idle && pending != none) begin
                state       <= (pending == player_a) ? held_a : held_b;
                claim_valid <= 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            held_a:  claim_player = player_a;
            held_b:  claim_player = player_b;
            default: claim_player = none;
        endcase
    end

endmodule

`default_nettype wire

// File: bell_judge.sv
`default_nettype none

module bell_judge (
    card_if.judge       cards,
    input  logic [3:0]  target_sum,
    output logic        correct
);

    logic [3:0] n1;
    logic [3:0] n2;
    logic [3:0] sum;

    assign n1  = 4'(cards.num1);
    assign n2  = 4'(cards.num2);
    assign sum = n1 + n2;  // wraps at 4 bits

    always_comb begin
        if (cards.color1 == cards.color2)
            correct = (sum == target_sum);
        else
            correct = (n1 == target_sum) || (n2 == target_sum);
    end

endmodule

`default_nettype wire

// File: round_scorer.sv
`default_nettype none

module round_scorer #(
    parameter int SCORE_W = 10
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         claim_valid,
    input  halli_pkg::player_t           claim_player,
    input  logic [halli_pkg::BONUS_W-1:0] bonus,
    input  logic [3:0]                   target_sum,
    card_if.judge                        cards,
    output logic                         delta_valid,
    output logic signed [SCORE_W-1:0]    delta_a,
    output logic signed [SCORE_W-1:0]    delta_b,
    output logic                         correct_q
);
    import halli_pkg::*;

    localparam logic signed [SCORE_W-1:0] unit = 1;

    logic                      correct;
    logic signed [SCORE_W-1:0] gain;
    logic signed [SCORE_W-1:0] claimer_d;
    logic signed [SCORE_W-1:0] other_d;

    bell_judge judge0 (
        .cards      (cards),
        .target_sum (target_sum),
        .correct    (correct)
    );

    assign gain      = SCORE_W'(bonus);  // zero extended
    assign claimer_d = correct ? gain : -unit;
    assign other_d   = correct ? '0 : unit;

    always_ff @(posedge clk) begin
        if (!rst) begin
            delta_valid <= 1'b0;
            correct_q   <= 1'b0;
        end else begin
            delta_valid <= claim_valid;
            if (claim_valid)
                correct_q <= correct;
        end
    end

    // deltas only meaningful with delta_valid
    always_ff @(posedge clk) begin
        if (claim_valid) begin
            if (claim_player == player_a) begin
                delta_a <= claimer_d;
                delta_b <= other_d;
            end else begin
                delta_a <= other_d;
                delta_b <= claimer_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: score_bank.sv
`default_nettype none

module score_bank #(
    parameter int SCORE_W = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      delta_valid,
    input  logic signed [SCORE_W-1:0] delta_a,
    input  logic signed [SCORE_W-1:0] delta_b,
    output logic signed [SCORE_W-1:0] total_a,
    output logic signed [SCORE_W-1:0] total_b
);

    // plain wraparound accumulators
    always_ff @(posedge clk) begin
        if (!rst) begin
            total_a <= '0;
            total_b <= '0;
        end else if (delta_valid) begin
            total_a <= total_a + delta_a;
            total_b <= total_b + delta_b;
        end
    end

endmodule

`default_nettype wire

// File: match_referee.sv
`default_nettype none

module match_referee #(
    parameter int SCORE_W = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic signed [SCORE_W-1:0] total_a,
    input  logic signed [SCORE_W-1:0] total_b,
    input  logic [7:0]                win_margin,
    output halli_pkg::player_t        leader
);
    import halli_pkg::*;

    // one bit over the wider of score and zero-extended margin
    localparam int EXT_W = ((SCORE_W > 9) ? SCORE_W : 9) + 1;

    logic signed [EXT_W-1:0] a_ext;
    logic signed [EXT_W-1:0] b_ext;
    logic signed [EXT_W-1:0] m_ext;

    assign a_ext = EXT_W'(total_a);     // sign extended
    assign b_ext = EXT_W'(total_b);
    assign m_ext = EXT_W'(win_margin);  // margin is unsigned

    always_ff @(posedge clk) begin
        if (!rst)
            leader <= none;
        else if (a_ext > b_ext + m_ext)
            leader <= player_a;
        else if (b_ext > a_ext + m_ext)
            leader <= player_b;
        else
            leader <= none;
    end

endmodule

`default_nettype wire

// File: halli_top.sv
`default_nettype none

module halli_top #(
    parameter int SCORE_W = 10
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [halli_pkg::KEY_W-1:0]      key,
    input  logic                            round_clear,
    input  logic [halli_pkg::COLOR_W-1:0]    color1,
    input  logic [halli_pkg::COLOR_W-1:0]    color2,
    input  logic [halli_pkg::NUM_W-1:0]      num1,
    input  logic [halli_pkg::NUM_W-1:0]      num2,
    input  logic [halli_pkg::BONUS_W-1:0]    bonus,
    input  logic                            cfg_we,
    input  logic [halli_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [7:0]                      cfg_wdata,
    output logic signed [SCORE_W-1:0]       total_a,
    output logic signed [SCORE_W-1:0]       total_b,
    output halli_pkg::player_t              leader,
    output logic                            last_correct,
    output logic                            last_valid
);

    logic                      claim_valid;
    halli_pkg::player_t        claim_player;
    logic                      delta_valid;
    logic signed [SCORE_W-1:0] delta_a;
    logic signed [SCORE_W-1:0] delta_b;
    logic                      correct_q;
    logic [3:0]                target_sum;
    logic [7:0]                win_margin;

    card_if cards ();

    // cards held steady by the dealer for the whole round
    assign cards.color1 = color1;
    assign cards.color2 = color2;
    assign cards.num1   = num1;
    assign cards.num2   = num2;

    game_config cfg0 (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .target_sum (target_sum),
        .win_margin (win_margin)
    );

    buzz_arbiter arb0 (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .round_clear  (round_clear),
        .claim_valid  (claim_valid),
        .claim_player (claim_player)
    );

    round_scorer #(.SCORE_W(SCORE_W)) scorer0 (
        .clk          (clk),
        .rst          (rst),
        .claim_valid  (claim_valid),
        .claim_player (claim_player),
        .bonus        (bonus),
        .target_sum   (target_sum),
        .cards        (cards),
        .delta_valid  (delta_valid),
        .delta_a      (delta_a),
        .delta_b      (delta_b),
        .correct_q    (correct_q)
    );

    score_bank #(.SCORE_W(SCORE_W)) bank0 (
        .clk         (clk),
        .rst         (rst),
        .delta_valid (delta_valid),
        .delta_a     (delta_a),
        .delta_b     (delta_b),
        .total_a     (total_a),
        .total_b     (total_b)
    );

    match_referee #(.SCORE_W(SCORE_W)) ref0 (
        .clk        (clk),
        .rst        (rst),
        .total_a    (total_a),
        .total_b    (total_b),
        .win_margin (win_margin),
        .leader     (leader)
    );

    assign last_valid   = delta_valid;
    assign last_correct = correct_q;

endmodule

`default_nettype wire

// File: tb_halli.sv
`default_nettype none

module tb_halli;
    import halli_pkg::*;

    localparam int SCORE_W    = 10;
    localparam int NUM_ROWS   = 15;
    localparam int WAIT_LIMIT = 20;

    typedef struct packed {
        logic                  is_cfg;
        logic [CFG_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
        logic [COLOR_W-1:0]    c1;
        logic [COLOR_W-1:0]    c2;
        logic [NUM_W-1:0]      n1;
        logic [NUM_W-1:0]      n2;
        logic [KEY_W-1:0]      key;
        logic [KEY_W-1:0]      key2;   // late press by the other player or 0
        logic [BONUS_W-1:0]    bonus;
        logic                  rnd_bonus;
        logic                  exp_ok;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic [KEY_W-1:0]          key;
    logic                      round_clear;
    logic [COLOR_W-1:0]        color1;
    logic [COLOR_W-1:0]        color2;
    logic [NUM_W-1:0]          num1;
    logic [NUM_W-1:0]          num2;
    logic [BONUS_W-1:0]        bonus;
    logic                      cfg_we;
    logic [CFG_ADDR_W-1:0]     cfg_addr;
    logic [7:0]                cfg_wdata;
    logic signed [SCORE_W-1:0] total_a;
    logic signed [SCORE_W-1:0] total_b;
    player_t                   leader;
    logic                      last_correct;
    logic                      last_valid;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr = 32'hcd3b_abe8;
    int          exp_a;
    int          exp_b;
    int          model_margin;

    halli_top #(.SCORE_W(SCORE_W)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .round_clear  (round_clear),
        .color1       (color1),
        .color2       (color2),
        .num1         (num1),
        .num2         (num2),
        .bonus        (bonus),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .total_a      (total_a),
        .total_b      (total_b),
        .leader       (leader),
        .last_correct (last_correct),
        .last_valid   (last_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string msg);
        end_with_failure($sformatf("Fail at time %0t: %s", $time, msg));
    endtask

    // four-state compare so unknown bits count as a mismatch
    task automatic expect_int(input logic signed [31:0] got, input logic signed [31:0] exp,
                              input string what);
        assert (got === exp)
        else report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            lfsr_step = (s >> 1) ^ 32'h8020_0003;
        else
            lfsr_step = s >> 1;
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < nbits; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // totals live in SCORE_W bits and wrap
    function automatic int wrap_score(input int v);
        logic [SCORE_W-1:0] low;
        low = v[SCORE_W-1:0];
        wrap_score = int'($signed(low));
    endfunction

    function automatic player_t leader_of(input int a, input int b, input int m);
        if (a > b + m)
            return player_a;
        else if (b > a + m)
            return player_b;
        else
            return none;
    endfunction

    function automatic row_t make_round(
        input logic [COLOR_W-1:0] c1,
        input logic [COLOR_W-1:0] c2,
        input logic [NUM_W-1:0]   n1,
        input logic [NUM_W-1:0]   n2,
        input logic [KEY_W-1:0]   k,
        input logic [KEY_W-1:0]   k2,
        input logic [BONUS_W-1:0] b,
        input logic               rnd,
        input logic               ok
    );
        row_t r;
        r           = '0;
        r.c1        = c1;
        r.c2        = c2;
        r.n1        = n1;
        r.n2        = n2;
        r.key       = k;
        r.key2      = k2;
        r.bonus     = b;
        r.rnd_bonus = rnd;
        r.exp_ok    = ok;
        return r;
    endfunction

    function automatic row_t make_cfg(input logic [CFG_ADDR_W-1:0] a, input logic [7:0] d);
        row_t r;
        r        = '0;
        r.is_cfg = 1'b1;
        r.addr   = a;
        r.wdata  = d;
        return r;
    endfunction

    task automatic write_config(input row_t r);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_addr  = r.addr;
        cfg_wdata = r.wdata;
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
        if (r.addr == CFG_MARGIN)
            model_margin = int'(r.wdata);
        @(posedge clk);  // leader picks up the new margin here
        @(negedge clk);
        expect_int(32'(leader), int'(leader_of(exp_a, exp_b, model_margin)),
                   "leader after config write");
    endtask

    task automatic run_round(input row_t r);
        logic [31:0]        rv;
        logic [BONUS_W-1:0] b;
        int                 waited;
        b = r.bonus;
        if (r.rnd_bonus) begin
            draw_bits(5, rv);
            b = {3'b000, rv[4:0]};
        end
        @(posedge clk);
        #2;
        color1      = r.c1;
        color2      = r.c2;
        num1        = r.n1;
        num2        = r.n2;
        bonus       = b;
        key         = '0;
        round_clear = 1'b1;
        @(posedge clk);
        #2;
        round_clear = 1'b0;
        key         = r.key;
        @(posedge clk);  // press edge
        #2;
        key = r.key2;
        @(posedge clk);
        #2;
        key = '0;

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                end_with_failure("timed out waiting for last_valid after a key press");
        end while (!last_valid);
        expect_int(32'(last_correct), int'(r.exp_ok), "last_correct");

        if (r.exp_ok) begin
            if (r.key == KEY_P1)
                exp_a = wrap_score(exp_a + int'(b));
            else
                exp_b = wrap_score(exp_b + int'(b));
        end else if (r.key == KEY_P1) begin
            exp_a = wrap_score(exp_a - 1);
            exp_b = wrap_score(exp_b + 1);
        end else begin
            exp_b = wrap_score(exp_b - 1);
            exp_a = wrap_score(exp_a + 1);
        end

        @(negedge clk);  // three cycles after the press
        expect_int(32'(total_a), exp_a, "total_a");
        expect_int(32'(total_b), exp_b, "total_b");
        expect_int(32'(last_valid), 0, "second last_valid");
        @(negedge clk);
        expect_int(32'(leader), int'(leader_of(exp_a, exp_b, model_margin)), "leader");
        expect_int(32'(last_valid), 0, "late last_valid");
    endtask

    initial begin
        rst          = 1'b0;
        key          = '0;
        round_clear  = 1'b0;
        color1       = '0;
        color2       = '0;
        num1         = '0;
        num2         = '0;
        bonus        = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        exp_a        = 0;
        exp_b        = 0;
        model_margin = int'(MARGIN_DEFAULT);

        // target 5 and margin 50
        rows[0]  = make_round(2'd1, 2'd1, 3'd2, 3'd3, KEY_P1, 4'd0, 8'd20, 1'b0, 1'b1);
        rows[1]  = make_round(2'd2, 2'd2, 3'd3, 3'd3, KEY_P2, 4'd0, 8'd30, 1'b0, 1'b0);
        rows[2]  = make_round(2'd0, 2'd3, 3'd5, 3'd1, KEY_P2, 4'd0, 8'd40, 1'b0, 1'b1);
        rows[3]  = make_round(2'd1, 2'd2, 3'd4, 3'd2, KEY_P1, KEY_P2, 8'd10, 1'b0, 1'b0);
        rows[4]  = make_round(2'd3, 2'd3, 3'd4, 3'd1, KEY_P1, 4'd0, 8'd70, 1'b0, 1'b1);
        rows[5]  = make_round(2'd0, 2'd1, 3'd0, 3'd5, KEY_P1, 4'd0, 8'd1, 1'b0, 1'b1);
        rows[6]  = make_round(2'd2, 2'd2, 3'd7, 3'd6, KEY_P1, 4'd0, 8'd9, 1'b0, 1'b0);
        rows[7]  = make_round(2'd1, 2'd1, 3'd5, 3'd0, KEY_P2, 4'd0, 8'd0, 1'b1, 1'b1);
        rows[8]  = make_round(2'd3, 2'd0, 3'd6, 3'd7, KEY_P2, KEY_P1, 8'd5, 1'b0, 1'b0);
        // new rules
        rows[9]  = make_cfg(CFG_TARGET, 8'd6);
        rows[10] = make_cfg(CFG_MARGIN, 8'd10);
        rows[11] = make_round(2'd1, 2'd1, 3'd2, 3'd3, KEY_P1, 4'd0, 8'd15, 1'b0, 1'b0);
        rows[12] = make_round(2'd2, 2'd2, 3'd3, 3'd3, KEY_P2, 4'd0, 8'd0, 1'b1, 1'b1);
        rows[13] = make_round(2'd0, 2'd2, 3'd6, 3'd1, KEY_P2, 4'd0, 8'd100, 1'b0, 1'b1);
        rows[14] = make_round(2'd3, 2'd1, 3'd5, 3'd4, KEY_P1, KEY_P2, 8'd3, 1'b0, 1'b0);

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        expect_int(32'(total_a), 0, "total_a after reset");
        expect_int(32'(total_b), 0, "total_b after reset");
        expect_int(32'(leader), int'(none), "leader after reset");
        expect_int(32'(last_valid), 0, "last_valid after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].is_cfg)
                write_config(rows[i]);
            else
                run_round(rows[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
halli_pkg.sv
card_if.sv
game_config.sv
buzz_arbiter.sv
bell_judge.sv
round_scorer.sv
score_bank.sv
match_referee.sv
halli_top.sv
tb_halli.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_halli
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
